// ==== files.f ====
+incdir+src
src/card_req_pkg.sv
src/seq_queue.sv
src/dest_req_arb.sv
src/card_data_router.sv
src/card_req_mux.sv
verification/card_req_mux_assert.sv
verification/card_req_mux_tb.sv

// ==== src/card_data_router.sv ====
// Steers card read data beats to the head request's destination and flags the last beat
`timescale 1ns/1ps
`default_nettype none

`include "card_req_params.svh"

module card_data_router (
    input  logic                                   aclk,
    input  logic                                   aresetn,

    // Head of the sequence queue
    input  logic                                   seq_valid,
    output logic                                   seq_ready,
    input  card_req_pkg::mux_seq_t                 seq,

    // Card read data
    input  logic                                   s_card_valid,
    output logic                                   s_card_ready,
    input  logic [`DATA_BITS-1:0]                  s_card_data,

    // Per destination beats
    output logic [`N_DESTS-1:0]                    m_data_valid,
    input  logic [`N_DESTS-1:0]                    m_data_ready,
    output card_req_pkg::beat_t [`N_DESTS-1:0]     m_data
);

    // Beats forwarded for the head request
    logic [`LEN_BITS-1:0] beat_cnt;
    logic                 is_last;
    logic                 beat_fire;

    // ------------------------------------------------
    // Beat steering
    // ------------------------------------------------

    assign is_last = (beat_cnt == seq.n_beats_m1);

    // Card stalls without a head entry or when that destination stalls
    assign s_card_ready = seq_valid & m_data_ready[seq.dest];
    assign beat_fire    = s_card_valid & s_card_ready;

    // Entry leaves with its final beat
    assign seq_ready = beat_fire & is_last;

    // Only the head destination sees valid
    always_comb begin
        m_data_valid = '0;
        if (seq_valid) begin
            m_data_valid[seq.dest] = s_card_valid;
        end
    end

    // Same payload on every lane, valid picks the receiver
    always_comb begin
        for (int i = 0; i < `N_DESTS; i++) begin
            m_data[i].data = s_card_data;
            m_data[i].last = is_last;
        end
    end

    // ------------------------------------------------
    // Beat counter
    // ------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (beat_fire) begin
            // Wrap to zero at the request boundary
            if (is_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/card_req_mux.sv ====
// Card request mux top, arbitrates destination reads and routes read data back
`timescale 1ns/1ps
`default_nettype none

`include "card_req_params.svh"

module card_req_mux (
    input  logic                                   aclk,
    input  logic                                   aresetn,

    // Destination requests
    input  logic [`N_DESTS-1:0]                    s_req_valid,
    output logic [`N_DESTS-1:0]                    s_req_ready,
    input  card_req_pkg::req_t [`N_DESTS-1:0]      s_req,

    // Card request port
    output logic                                   m_req_valid,
    input  logic                                   m_req_ready,
    output card_req_pkg::req_t                     m_req,

    // Card read data
    input  logic                                   s_card_valid,
    output logic                                   s_card_ready,
    input  logic [`DATA_BITS-1:0]                  s_card_data,

    // Destination data
    output logic [`N_DESTS-1:0]                    m_data_valid,
    input  logic [`N_DESTS-1:0]                    m_data_ready,
    output card_req_pkg::beat_t [`N_DESTS-1:0]     m_data
);

    // Request register depth
    localparam int REQ_DEPTH = 2;

    // Grant path
    logic                   grant_valid;
    logic                   req_q_ready;
    logic                   seq_q_ready;
    card_req_pkg::req_t     grant_req;
    card_req_pkg::mux_seq_t grant_seq;

    // Sequence head towards the router
    logic                   seq_valid;
    logic                   seq_ready;
    card_req_pkg::mux_seq_t seq_head;

    // ------------------------------------------------
    // Arbiter and queues
    // ------------------------------------------------

    dest_req_arb u_arb (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req       (s_req),
        .grant_valid (grant_valid),
        .req_q_ready (req_q_ready),
        .seq_q_ready (seq_q_ready),
        .grant_req   (grant_req),
        .grant_seq   (grant_seq)
    );

    // Outgoing request register
    seq_queue #(.QTYPE(card_req_pkg::req_t), .QDEPTH(REQ_DEPTH)) u_req_q (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .val_snk  (grant_valid),
        .rdy_snk  (req_q_ready),
        .data_snk (grant_req),
        .val_src  (m_req_valid),
        .rdy_src  (m_req_ready),
        .data_src (m_req)
    );

    // Outstanding request order, bounds requests in flight
    seq_queue #(.QTYPE(card_req_pkg::mux_seq_t), .QDEPTH(`SEQ_DEPTH)) u_seq_q (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .val_snk  (grant_valid),
        .rdy_snk  (seq_q_ready),
        .data_snk (grant_seq),
        .val_src  (seq_valid),
        .rdy_src  (seq_ready),
        .data_src (seq_head)
    );

    // ------------------------------------------------
    // Data return
    // ------------------------------------------------

    card_data_router u_router (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .seq_valid    (seq_valid),
        .seq_ready    (seq_ready),
        .seq          (seq_head),
        .s_card_valid (s_card_valid),
        .s_card_ready (s_card_ready),
        .s_card_data  (s_card_data),
        .m_data_valid (m_data_valid),
        .m_data_ready (m_data_ready),
        .m_data       (m_data)
    );

endmodule

`default_nettype wire

// ==== src/card_req_params.svh ====
// Card request mux widths, destination count and outstanding request depth
`ifndef CARD_REQ_PARAMS_SVH
`define CARD_REQ_PARAMS_SVH

// Destinations (user streams) sharing the card port
`define N_DESTS 4
`define DEST_BITS 2

// Request fields
`define PID_BITS 6
`define LEN_BITS 16
`define VADDR_BITS 32

// Card data path, 8 bytes per beat
`define DATA_BITS 64
`define BEAT_LOG_BITS 3

// Outstanding requests tracked by the router
`define SEQ_DEPTH 8

`endif

// ==== src/card_req_pkg.sv ====
// Shared request, sequence entry and data beat types of the card request mux
`default_nettype none

`include "card_req_params.svh"

package card_req_pkg;

    // ------------------------------------------------
    // Request side
    // ------------------------------------------------

    // One read request, len counted in bytes
    typedef struct packed {
        logic [`VADDR_BITS-1:0] vaddr;
        logic [`LEN_BITS-1:0]   len;
        logic [`PID_BITS-1:0]   pid;
    } req_t;

    // Routing record per granted request
    // n_beats_m1 holds the beat count minus one
    typedef struct packed {
        logic [`DEST_BITS-1:0] dest;
        logic [`LEN_BITS-1:0]  n_beats_m1;
    } mux_seq_t;

    // ------------------------------------------------
    // Data side
    // ------------------------------------------------

    // Beat towards a destination, last closes a request
    typedef struct packed {
        logic [`DATA_BITS-1:0] data;
        logic                  last;
    } beat_t;

endpackage

`default_nettype wire

// ==== src/dest_req_arb.sv ====
// Round-robin arbiter over destination read requests, emits request and sequence entry
`timescale 1ns/1ps
`default_nettype none

`include "card_req_params.svh"

module dest_req_arb (
    input  logic                                   aclk,
    input  logic                                   aresetn,

    // Destination requests
    input  logic [`N_DESTS-1:0]                    s_req_valid,
    output logic [`N_DESTS-1:0]                    s_req_ready,
    input  card_req_pkg::req_t [`N_DESTS-1:0]      s_req,

    // Grant towards request and sequence queues
    output logic                                   grant_valid,
    input  logic                                   req_q_ready,
    input  logic                                   seq_q_ready,
    output card_req_pkg::req_t                     grant_req,
    output card_req_pkg::mux_seq_t                 grant_seq
);

    // Round-robin start point
    logic [`DEST_BITS-1:0] rr_ptr;

    // Selected destination and its request
    logic [`DEST_BITS-1:0] sel;
    logic                  found;
    card_req_pkg::req_t    sel_req;

    // Search candidate index
    int unsigned cand;

    // Both queues must take the grant in the same cycle
    logic both_rdy;

    assign both_rdy = req_q_ready & seq_q_ready;

    // ------------------------------------------------
    // Selection
    // ------------------------------------------------

    // First valid destination at or after rr_ptr, wrapping around
    always_comb begin
        found = 1'b0;
        sel   = rr_ptr;
        cand  = 0;
        for (int i = 0; i < `N_DESTS; i++) begin
            cand = (int'(rr_ptr) + i) % `N_DESTS;
            if (!found && s_req_valid[cand]) begin
                found = 1'b1;
                sel   = `DEST_BITS'(cand);
            end
        end
    end

    assign sel_req     = s_req[sel];
    assign grant_valid = found & both_rdy;

    // Only the winner sees ready
    always_comb begin
        s_req_ready = '0;
        if (found && both_rdy) begin
            s_req_ready[sel] = 1'b1;
        end
    end

    // ------------------------------------------------
    // Grant payloads
    // ------------------------------------------------

    // Request goes out untouched
    assign grant_req = sel_req;

    // Sequence entry for the router
    assign grant_seq.dest = sel;
    // Beats minus one, len of zero is not a legal request
    assign grant_seq.n_beats_m1 = (sel_req.len - 1'b1) >> `BEAT_LOG_BITS;

    // ------------------------------------------------
    // Pointer update
    // ------------------------------------------------

    // Next search starts one past the last winner
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr_ptr <= '0;
        end else if (grant_valid) begin
            if (sel == `DEST_BITS'(`N_DESTS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= sel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/seq_queue.sv ====
// Synchronous circular-buffer FIFO for any payload type, valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module seq_queue #(
    parameter type QTYPE  = logic [7:0],
    parameter int  QDEPTH = 4
) (
    input  logic aclk,
    input  logic aresetn,

    // Push side
    input  logic val_snk,
    output logic rdy_snk,
    input  QTYPE data_snk,

    // Pop side
    output logic val_src,
    input  logic rdy_src,
    output QTYPE data_src
);

    // Pointer and occupancy widths
    localparam int PTR_BITS = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CNT_BITS = $clog2(QDEPTH + 1);

    // Entry storage, no reset needed
    QTYPE mem [QDEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    // Advance a pointer with wraparound at QDEPTH
    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(QDEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ------------------------------------------------
    // Handshakes
    // ------------------------------------------------

    assign val_src = (count != '0);
    // Full queue still takes a push when the head leaves this cycle
    assign rdy_snk = (count != CNT_BITS'(QDEPTH)) || rdy_src;
    assign push    = val_snk & rdy_snk;
    assign pop     = val_src & rdy_src;

    // Head entry straight out of the storage flops
    assign data_src = mem[rd_ptr];

    // ------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_snk;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Occupancy holds when both sides move
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/card_req_mux_assert.sv ====
// Bound protocol checks on the card request mux handshakes and reset behavior
`timescale 1ns/1ps
`default_nettype none

`include "card_req_params.svh"

module card_req_mux_assert (
    input  logic                                   aclk,
    input  logic                                   aresetn,
    input  logic                                   m_req_valid,
    input  logic                                   m_req_ready,
    input  card_req_pkg::req_t                     m_req,
    input  logic                                   s_card_valid,
    input  logic                                   s_card_ready,
    input  logic [`DATA_BITS-1:0]                  s_card_data,
    input  logic [`N_DESTS-1:0]                    m_data_valid,
    input  logic [`N_DESTS-1:0]                    m_data_ready,
    input  card_req_pkg::beat_t [`N_DESTS-1:0]     m_data
);

    // ------------------------------------------------
    // Hold rules under back-pressure
    // ------------------------------------------------

    // Card request held while the card stalls
    a_req_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req))
        else $error("m_req dropped or changed while m_req_ready was low");

    // Beat towards each destination held while it stalls
    for (genvar d = 0; d < `N_DESTS; d++) begin : g_dest
        a_data_hold: assert property (@(posedge aclk) disable iff (!aresetn)
            m_data_valid[d] && !m_data_ready[d] |=> m_data_valid[d] && $stable(m_data[d]))
            else $error("beat to destination %0d changed while stalled", d);

        // Destination beat only together with the card beat it carries
        a_data_from_card: assert property (@(posedge aclk) disable iff (!aresetn)
            m_data_valid[d] && m_data_ready[d] |->
                s_card_valid && s_card_ready && (m_data[d].data == s_card_data))
            else $error("beat to destination %0d without the matching card beat", d);
    end

    // ------------------------------------------------
    // Routing and reset
    // ------------------------------------------------

    // One destination at a time
    a_one_dest: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0(m_data_valid))
        else $error("more than one m_data_valid high");

    // Outputs quiet once a reset edge has been seen
    a_reset_quiet: assert property (@(posedge aclk)
        !aresetn |=> (m_data_valid == '0) && !m_req_valid)
        else $error("valid output high during reset");

endmodule

bind card_req_mux card_req_mux_assert u_assert (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .m_req_valid  (m_req_valid),
    .m_req_ready  (m_req_ready),
    .m_req        (m_req),
    .s_card_valid (s_card_valid),
    .s_card_ready (s_card_ready),
    .s_card_data  (s_card_data),
    .m_data_valid (m_data_valid),
    .m_data_ready (m_data_ready),
    .m_data       (m_data)
);

`default_nettype wire

// ==== verification/card_req_mux_tb.sv ====
// Testbench for the card request mux, table-driven requests against a card memory model
`timescale 1ns/1ps
`default_nettype none

`include "card_req_params.svh"

module card_req_mux_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int N_REQS       = 16;

    // Table row, request fields plus expected beat count
    typedef struct packed {
        logic [`DEST_BITS-1:0]  dest;
        logic [`VADDR_BITS-1:0] vaddr;
        logic [`LEN_BITS-1:0]   len;
        logic [`PID_BITS-1:0]   pid;
        logic [`LEN_BITS-1:0]   n_beats;
    } tbl_entry_t;

    // Beat counts are ceil(len / 8), worked out by hand
    tbl_entry_t stim_tbl [N_REQS] = '{
        '{2'd0, 32'h1000_0000, 16'd64,  6'd1,  16'd8},
        '{2'd1, 32'h2000_0000, 16'd8,   6'd2,  16'd1},
        '{2'd2, 32'h3000_0000, 16'd9,   6'd3,  16'd2},
        '{2'd3, 32'h4000_0000, 16'd100, 6'd4,  16'd13},
        '{2'd0, 32'h1000_0100, 16'd1,   6'd5,  16'd1},
        '{2'd0, 32'h1000_0200, 16'd17,  6'd6,  16'd3},
        '{2'd2, 32'h3000_0100, 16'd40,  6'd7,  16'd5},
        '{2'd1, 32'h2000_0100, 16'd33,  6'd8,  16'd5},
        '{2'd3, 32'h4000_0200, 16'd16,  6'd9,  16'd2},
        '{2'd3, 32'h4000_0300, 16'd7,   6'd10, 16'd1},
        '{2'd1, 32'h2000_0200, 16'd72,  6'd11, 16'd9},
        '{2'd2, 32'h3000_0200, 16'd24,  6'd12, 16'd3},
        '{2'd0, 32'h1000_0300, 16'd50,  6'd13, 16'd7},
        '{2'd1, 32'h2000_0300, 16'd120, 6'd14, 16'd15},
        '{2'd2, 32'h3000_0300, 16'd200, 6'd15, 16'd25},
        '{2'd3, 32'h4000_0400, 16'd256, 6'd16, 16'd32}
    };

    logic                                   aclk;
    logic                                   aresetn;
    logic [`N_DESTS-1:0]                    s_req_valid;
    logic [`N_DESTS-1:0]                    s_req_ready;
    card_req_pkg::req_t [`N_DESTS-1:0]      s_req;
    logic                                   m_req_valid;
    logic                                   m_req_ready;
    card_req_pkg::req_t                     m_req;
    logic                                   s_card_valid;
    logic                                   s_card_ready;
    logic [`DATA_BITS-1:0]                  s_card_data;
    logic [`N_DESTS-1:0]                    m_data_valid;
    logic [`N_DESTS-1:0]                    m_data_ready;
    card_req_pkg::beat_t [`N_DESTS-1:0]     m_data;

    // Rows not yet granted, and rows whose data is still due, per destination
    int pend [`N_DESTS][$];
    int dest_exp [`N_DESTS][$];
    int dest_beat [`N_DESTS];
    // Granted rows on their way to m_req, then rows the card owes data for
    int mreq_exp [$];
    int card_q [$];
    int card_beat;
    int rr_model;
    int beats_left;

    // Handshakes seen before the coming edge
    logic [`N_DESTS-1:0] req_fire;
    logic                mreq_fire;
    logic                card_fire;
    logic [31:0]         lcg_state = 32'h507e;

    initial aclk = 1'b0;
    always #(CLK_PERIOD / 2) aclk = ~aclk;

    card_req_mux u_dut (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .s_req_valid  (s_req_valid),
        .s_req_ready  (s_req_ready),
        .s_req        (s_req),
        .m_req_valid  (m_req_valid),
        .m_req_ready  (m_req_ready),
        .m_req        (m_req),
        .s_card_valid (s_card_valid),
        .s_card_ready (s_card_ready),
        .s_card_data  (s_card_data),
        .m_data_valid (m_data_valid),
        .m_data_ready (m_data_ready),
        .m_data       (m_data)
    );

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // High three times in four, from the upper bits
    function automatic logic rand_likely();
        logic [31:0] r;
        r = lcg_next();
        return r[31:30] != 2'b00;
    endfunction

    function automatic card_req_pkg::req_t row_req(input int row);
        card_req_pkg::req_t r;
        r.vaddr = stim_tbl[row].vaddr;
        r.len   = stim_tbl[row].len;
        r.pid   = stim_tbl[row].pid;
        return r;
    endfunction

    // First valid index at or after ptr, with wraparound
    function automatic int rr_predict(input int ptr, input logic [`N_DESTS-1:0] valid);
        int idx;
        for (int i = 0; i < `N_DESTS; i++) begin
            idx = (ptr + i) % `N_DESTS;
            if (valid[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic check_dest(input logic [`DEST_BITS-1:0] got, input logic [`DEST_BITS-1:0] exp);
        if (got !== exp) begin
            value_error($sformatf("granted destination %0d, expected %0d", got, exp));
        end
    endtask

    task automatic check_req(input card_req_pkg::req_t got, input card_req_pkg::req_t exp);
        if (got !== exp) begin
            value_error($sformatf("m_req %h, expected %h", got, exp));
        end
    endtask

    task automatic check_beat(input int dest, input card_req_pkg::beat_t got,
                              input card_req_pkg::beat_t exp);
        if (got !== exp) begin
            value_error($sformatf("dest %0d beat data %h last %b, expected data %h last %b",
                                  dest, got.data, got.last, exp.data, exp.last));
        end
    endtask

    // ------------------------------------------------
    // Stimulus and checking per cycle
    // ------------------------------------------------

    task automatic load_table();
        for (int i = 0; i < N_REQS; i++) begin
            pend[stim_tbl[i].dest].push_back(i);
            dest_exp[stim_tbl[i].dest].push_back(i);
            beats_left += int'(stim_tbl[i].n_beats);
        end
        for (int d = 0; d < `N_DESTS; d++) begin
            dest_beat[d] = 0;
        end
    endtask

    // Runs just after a rising edge, retires last cycle's handshakes
    task automatic drive_inputs();
        for (int d = 0; d < `N_DESTS; d++) begin
            if (req_fire[d]) begin
                void'(pend[d].pop_front());
            end
            // Valid held until accepted, raised at random gaps
            if (!s_req_valid[d] || req_fire[d]) begin
                s_req_valid[d] = 1'b0;
                if (pend[d].size() > 0 && rand_likely()) begin
                    s_req_valid[d] = 1'b1;
                    s_req[d]       = row_req(pend[d][0]);
                end
            end
            m_data_ready[d] = rand_likely();
        end
        m_req_ready = rand_likely();
        // Card memory model, beats in request order
        if (card_fire) begin
            card_beat++;
            if (card_beat == int'(stim_tbl[card_q[0]].n_beats)) begin
                void'(card_q.pop_front());
                card_beat = 0;
            end
        end
        if (!s_card_valid || card_fire) begin
            s_card_valid = 1'b0;
            if (card_q.size() > 0 && rand_likely()) begin
                s_card_valid = 1'b1;
                s_card_data  = `DATA_BITS'(stim_tbl[card_q[0]].vaddr) + `DATA_BITS'(card_beat);
            end
        end
    endtask

    // Runs at the falling edge, where every output has settled
    task automatic sample_outputs();
        int                  d_fired;
        int                  row;
        int                  data_fires;
        card_req_pkg::beat_t exp_beat;

        req_fire = s_req_valid & s_req_ready;
        if ($countones(req_fire) > 1) begin
            $display("More than one destination request accepted in one cycle");
            stop_with_failure();
        end
        if (req_fire != '0) begin
            d_fired = 0;
            for (int d = 0; d < `N_DESTS; d++) begin
                if (req_fire[d]) begin
                    d_fired = d;
                end
            end
            check_dest(`DEST_BITS'(d_fired), `DEST_BITS'(rr_predict(rr_model, s_req_valid)));
            rr_model = (d_fired + 1) % `N_DESTS;
            mreq_exp.push_back(pend[d_fired][0]);
        end

        mreq_fire = m_req_valid & m_req_ready;
        if (mreq_fire) begin
            if (mreq_exp.size() == 0) begin
                $display("Card request sent without a matching granted request");
                stop_with_failure();
            end
            row = mreq_exp.pop_front();
            check_req(m_req, row_req(row));
            card_q.push_back(row);
        end

        card_fire  = s_card_valid & s_card_ready;
        data_fires = 0;
        for (int d = 0; d < `N_DESTS; d++) begin
            if (m_data_valid[d] && m_data_ready[d]) begin
                data_fires++;
                if (dest_exp[d].size() == 0) begin
                    $display("Destination %0d received a beat it never asked for", d);
                    stop_with_failure();
                end
                row           = dest_exp[d][0];
                exp_beat.data = `DATA_BITS'(stim_tbl[row].vaddr) + `DATA_BITS'(dest_beat[d]);
                exp_beat.last = (dest_beat[d] == int'(stim_tbl[row].n_beats) - 1);
                check_beat(d, m_data[d], exp_beat);
                dest_beat[d]++;
                if (exp_beat.last) begin
                    void'(dest_exp[d].pop_front());
                    dest_beat[d] = 0;
                end
                beats_left--;
            end
        end
        // Every card beat lands on exactly one destination
        if (data_fires != int'(card_fire)) begin
            $display("Card beat and destination beat counts disagree in one cycle");
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------

    initial begin
        aresetn      = 1'b0;
        s_req_valid  = '0;
        s_req        = '0;
        m_req_ready  = 1'b0;
        s_card_valid = 1'b0;
        s_card_data  = '0;
        m_data_ready = '0;
        req_fire     = '0;
        mreq_fire    = 1'b0;
        card_fire    = 1'b0;
        card_beat    = 0;
        rr_model     = 0;
        beats_left   = 0;
        load_table();

        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(negedge aclk);
        if (m_req_valid !== 1'b0 || m_data_valid !== '0 || s_req_ready !== '0) begin
            $display("Valid or ready output high right after reset");
            stop_with_failure();
        end

        while (beats_left > 0) begin
            @(posedge aclk);
            #1;
            drive_inputs();
            @(negedge aclk);
            sample_outputs();
        end

        // Retire the last handshake, then expect a drained DUT
        @(posedge aclk);
        #1;
        drive_inputs();
        @(negedge aclk);
        if (mreq_exp.size() == 0 && card_q.size() == 0 && !m_req_valid && m_data_valid == '0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Requests still outstanding after all beats were received");
            stop_with_failure();
        end
    end

    initial begin
        #(N_REQS * 64 * CLK_PERIOD);
        $display("Timeout, requests did not complete within %0d cycles", N_REQS * 64);
        stop_with_failure();
    end

endmodule

`default_nettype wire
